// File: build.f
src/metering_pkg.sv
src/pixel_stream_if.sv
src/window_tracker.sv
src/brightness_accumulator.sv
src/metering_regs.sv
src/metering_top.sv
verif/metering_checker.sv
verif/tb_metering_top.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the metering testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_metering_top -f build.f \
    > sim.log 2>&1 && ./obj_dir/Vtb_metering_top >> sim.log 2>&1
sim_status=$?
cat sim.log
[ "$sim_status" -eq 0 ] && ! grep -q "TESTBENCH FAILED" sim.log \
    && echo "Simulation run passed" && exit 0 \
    || { echo "Simulation run failed, see sim.log"; exit 1; }

// File: src/brightness_accumulator.sv
//////////////////////////////
// Window brightness accumulator
// Sums each channel over the window and holds
// the 8-bit averages of the last frame
//////////////////////////////

`timescale 1ns/1ps

module brightness_accumulator (
    input  logic                      pixel_clock_in,
    input  logic                      arst_n,
    pixel_stream_if.sink              pixels,
    input  logic                      in_window,
    input  logic                      frame_end,
    output metering_pkg::brightness_t red_average,
    output metering_pkg::brightness_t green_average,
    output metering_pkg::brightness_t blue_average,
    output logic                      result_strobe
);
    import metering_pkg::*;

    channel_sum_t red_sum;
    channel_sum_t green_sum;
    channel_sum_t blue_sum;

    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (!pixels.frame_valid) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (in_window) begin
            red_sum   <= red_sum + channel_sum_t'(pixels.red);
            green_sum <= green_sum + channel_sum_t'(pixels.green);
            blue_sum  <= blue_sum + channel_sum_t'(pixels.blue);
        end
    end

    // The sums still hold the finished frame on the frame_end cycle
    // and are cleared at the same edge that captures them
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            red_average   <= '0;
            green_average <= '0;
            blue_average  <= '0;
            result_strobe <= 1'b0;
        end else begin
            result_strobe <= frame_end;
            if (frame_end) begin
                // With a 512 by 512 window this is the mean divided by 4
                red_average   <= red_sum[AVERAGE_LSB +: BRIGHTNESS_WIDTH];
                green_average <= green_sum[AVERAGE_LSB +: BRIGHTNESS_WIDTH];
                blue_average  <= blue_sum[AVERAGE_LSB +: BRIGHTNESS_WIDTH];
            end
        end
    end

endmodule

// File: src/metering_pkg.sv
//////////////////////////////
// Auto-exposure metering package
// Window geometry, data widths, register map
// and the AXI slave state encoding
//////////////////////////////

package metering_pkg;

    localparam int PIXEL_WIDTH       = 10;
    localparam int COORD_WIDTH       = 12;
    localparam int BRIGHTNESS_WIDTH  = 8;
    localparam int SUM_WIDTH         = 28;
    localparam int FRAME_COUNT_WIDTH = 16;
    localparam int AXI_ADDR_WIDTH    = 8;
    localparam int AXI_DATA_WIDTH    = 32;

    typedef logic [PIXEL_WIDTH-1:0]       pixel_t;
    typedef logic [COORD_WIDTH-1:0]       coord_t;
    typedef logic [BRIGHTNESS_WIDTH-1:0]  brightness_t;
    typedef logic [SUM_WIDTH-1:0]         channel_sum_t;
    typedef logic [FRAME_COUNT_WIDTH-1:0] frame_count_t;
    typedef logic [AXI_ADDR_WIDTH-1:0]    axi_addr_t;
    typedef logic [AXI_DATA_WIDTH-1:0]    axi_data_t;

    // The window is square so the mean is a fixed shift of the sum
    localparam int WINDOW_SIZE = 512;
    localparam int AVERAGE_LSB = 20;

    // Centres the window in a 1280 by 720 frame
    localparam coord_t X_START_RESET = 12'd384;
    localparam coord_t Y_START_RESET = 12'd104;

    localparam axi_addr_t REG_WINDOW_X    = 8'h00;
    localparam axi_addr_t REG_WINDOW_Y    = 8'h04;
    localparam axi_addr_t REG_RESULT      = 8'h08;
    localparam axi_addr_t REG_FRAME_COUNT = 8'h0C;
    localparam axi_addr_t REG_STATUS      = 8'h10;

    localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        IDLE,
        WRITE_RESP,
        READ_DATA
    } axi_state_t;

endpackage

// File: src/metering_regs.sv
//////////////////////////////
// Metering register block
// AXI4-Lite slave for window control, results,
// frame count and result-ready status
//////////////////////////////

`timescale 1ns/1ps

module metering_regs (
    input  logic                      pixel_clock_in,
    input  logic                      arst_n,
    input  metering_pkg::axi_addr_t   s_axi_awaddr,
    input  logic                      s_axi_awvalid,
    output logic                      s_axi_awready,
    input  metering_pkg::axi_data_t   s_axi_wdata,
    input  logic                      s_axi_wvalid,
    output logic                      s_axi_wready,
    output logic [1:0]                s_axi_bresp,
    output logic                      s_axi_bvalid,
    input  logic                      s_axi_bready,
    input  metering_pkg::axi_addr_t   s_axi_araddr,
    input  logic                      s_axi_arvalid,
    output logic                      s_axi_arready,
    output metering_pkg::axi_data_t   s_axi_rdata,
    output logic [1:0]                s_axi_rresp,
    output logic                      s_axi_rvalid,
    input  logic                      s_axi_rready,
    input  metering_pkg::brightness_t red_average,
    input  metering_pkg::brightness_t green_average,
    input  metering_pkg::brightness_t blue_average,
    input  logic                      result_strobe,
    output metering_pkg::coord_t      window_x_start,
    output metering_pkg::coord_t      window_y_start
);
    import metering_pkg::*;

    axi_state_t   state;
    frame_count_t frame_count;
    logic         result_ready;
    logic         write_fire;
    logic         read_fire;

    // The ready pulses are only raised from IDLE, so a handshake
    // can only complete while no response is outstanding
    assign write_fire = (state == IDLE) && s_axi_awready && s_axi_awvalid && s_axi_wvalid;
    assign read_fire  = (state == IDLE) && s_axi_arready && s_axi_arvalid && !write_fire;

    assign s_axi_bresp = AXI_RESP_OKAY;
    assign s_axi_rresp = AXI_RESP_OKAY;

    function automatic axi_data_t read_register(input axi_addr_t addr);
        axi_data_t value;
        value = '0;
        case (addr)
            REG_WINDOW_X:    value = axi_data_t'(window_x_start);
            REG_WINDOW_Y:    value = axi_data_t'(window_y_start);
            REG_RESULT:      value = {8'h00, red_average, green_average, blue_average};
            REG_FRAME_COUNT: value = axi_data_t'(frame_count);
            REG_STATUS:      value = axi_data_t'(result_ready);
            default:         value = '0;
        endcase
        return value;
    endfunction

    // Handshake sequencing
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            state         <= IDLE;
            s_axi_awready <= 1'b0;
            s_axi_wready  <= 1'b0;
            s_axi_arready <= 1'b0;
            s_axi_bvalid  <= 1'b0;
            s_axi_rvalid  <= 1'b0;
            s_axi_rdata   <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (write_fire) begin
                        s_axi_awready <= 1'b0;
                        s_axi_wready  <= 1'b0;
                        s_axi_bvalid  <= 1'b1;
                        state         <= WRITE_RESP;
                    end else if (read_fire) begin
                        s_axi_arready <= 1'b0;
                        s_axi_rdata   <= read_register(s_axi_araddr);
                        s_axi_rvalid  <= 1'b1;
                        state         <= READ_DATA;
                    end else if (s_axi_awvalid && s_axi_wvalid) begin
                        // Writes take priority over a read waiting at the same time
                        s_axi_awready <= 1'b1;
                        s_axi_wready  <= 1'b1;
                        s_axi_arready <= 1'b0;
                    end else if (s_axi_arvalid) begin
                        s_axi_arready <= 1'b1;
                    end else begin
                        s_axi_awready <= 1'b0;
                        s_axi_wready  <= 1'b0;
                        s_axi_arready <= 1'b0;
                    end
                end
                WRITE_RESP: begin
                    if (s_axi_bready) begin
                        s_axi_bvalid <= 1'b0;
                        state        <= IDLE;
                    end
                end
                READ_DATA: begin
                    if (s_axi_rready) begin
                        s_axi_rvalid <= 1'b0;
                        state        <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Register contents
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            window_x_start <= X_START_RESET;
            window_y_start <= Y_START_RESET;
            frame_count    <= '0;
            result_ready   <= 1'b0;
        end else begin
            if (write_fire && s_axi_awaddr == REG_WINDOW_X) begin
                window_x_start <= s_axi_wdata[COORD_WIDTH-1:0];
            end
            if (write_fire && s_axi_awaddr == REG_WINDOW_Y) begin
                window_y_start <= s_axi_wdata[COORD_WIDTH-1:0];
            end
            if (result_strobe) begin
                frame_count <= frame_count + 1'b1;
            end
            // A new result on the same cycle beats a software clear
            if (result_strobe) begin
                result_ready <= 1'b1;
            end else if (write_fire && s_axi_awaddr == REG_STATUS && s_axi_wdata[0]) begin
                result_ready <= 1'b0;
            end
        end
    end

endmodule

// File: src/metering_top.sv
//////////////////////////////
// Auto-exposure metering top level
// Pixel stream in, window averages out over AXI4-Lite
//////////////////////////////

`timescale 1ns/1ps

module metering_top (
    input  logic                    pixel_clock_in,
    input  logic                    arst_n,
    input  metering_pkg::pixel_t    pixel_red,
    input  metering_pkg::pixel_t    pixel_green,
    input  metering_pkg::pixel_t    pixel_blue,
    input  logic                    line_valid,
    input  logic                    frame_valid,
    input  metering_pkg::axi_addr_t s_axi_awaddr,
    input  logic                    s_axi_awvalid,
    output logic                    s_axi_awready,
    input  metering_pkg::axi_data_t s_axi_wdata,
    input  logic                    s_axi_wvalid,
    output logic                    s_axi_wready,
    output logic [1:0]              s_axi_bresp,
    output logic                    s_axi_bvalid,
    input  logic                    s_axi_bready,
    input  metering_pkg::axi_addr_t s_axi_araddr,
    input  logic                    s_axi_arvalid,
    output logic                    s_axi_arready,
    output metering_pkg::axi_data_t s_axi_rdata,
    output logic [1:0]              s_axi_rresp,
    output logic                    s_axi_rvalid,
    input  logic                    s_axi_rready
);

    pixel_stream_if pixel_bus ();

    logic                      in_window;
    logic                      frame_end;
    logic                      result_strobe;
    metering_pkg::brightness_t red_average;
    metering_pkg::brightness_t green_average;
    metering_pkg::brightness_t blue_average;
    metering_pkg::coord_t      window_x_start;
    metering_pkg::coord_t      window_y_start;

    // Source side of the pixel bundle
    assign pixel_bus.red         = pixel_red;
    assign pixel_bus.green       = pixel_green;
    assign pixel_bus.blue        = pixel_blue;
    assign pixel_bus.line_valid  = line_valid;
    assign pixel_bus.frame_valid = frame_valid;

    window_tracker u_window_tracker (
        .pixel_clock_in (pixel_clock_in),
        .arst_n         (arst_n),
        .pixels         (pixel_bus.sink),
        .window_x_start (window_x_start),
        .window_y_start (window_y_start),
        .in_window      (in_window),
        .frame_end      (frame_end)
    );

    brightness_accumulator u_brightness_accumulator (
        .pixel_clock_in (pixel_clock_in),
        .arst_n         (arst_n),
        .pixels         (pixel_bus.sink),
        .in_window      (in_window),
        .frame_end      (frame_end),
        .red_average    (red_average),
        .green_average  (green_average),
        .blue_average   (blue_average),
        .result_strobe  (result_strobe)
    );

    metering_regs u_metering_regs (
        .pixel_clock_in (pixel_clock_in),
        .arst_n         (arst_n),
        .s_axi_awaddr   (s_axi_awaddr),
        .s_axi_awvalid  (s_axi_awvalid),
        .s_axi_awready  (s_axi_awready),
        .s_axi_wdata    (s_axi_wdata),
        .s_axi_wvalid   (s_axi_wvalid),
        .s_axi_wready   (s_axi_wready),
        .s_axi_bresp    (s_axi_bresp),
        .s_axi_bvalid   (s_axi_bvalid),
        .s_axi_bready   (s_axi_bready),
        .s_axi_araddr   (s_axi_araddr),
        .s_axi_arvalid  (s_axi_arvalid),
        .s_axi_arready  (s_axi_arready),
        .s_axi_rdata    (s_axi_rdata),
        .s_axi_rresp    (s_axi_rresp),
        .s_axi_rvalid   (s_axi_rvalid),
        .s_axi_rready   (s_axi_rready),
        .red_average    (red_average),
        .green_average  (green_average),
        .blue_average   (blue_average),
        .result_strobe  (result_strobe),
        .window_x_start (window_x_start),
        .window_y_start (window_y_start)
    );

endmodule

// File: src/pixel_stream_if.sv
//////////////////////////////
// RGB pixel stream bundle
// Colour samples with line and frame framing
//////////////////////////////

`timescale 1ns/1ps

interface pixel_stream_if;
    import metering_pkg::*;

    pixel_t red;
    pixel_t green;
    pixel_t blue;
    logic   line_valid;
    logic   frame_valid;

    // The sink takes a pixel whenever both valids are high as there is no back-pressure
    modport source (
        output red, green, blue, line_valid, frame_valid
    );

    modport sink (
        input red, green, blue, line_valid, frame_valid
    );

endinterface

// File: src/window_tracker.sv
//////////////////////////////
// Metering window tracker
// Counts pixel position and flags the pixels
// inside the square metering window
//////////////////////////////

`timescale 1ns/1ps

module window_tracker (
    input  logic                 pixel_clock_in,
    input  logic                 arst_n,
    pixel_stream_if.sink         pixels,
    input  metering_pkg::coord_t window_x_start,
    input  metering_pkg::coord_t window_y_start,
    output logic                 in_window,
    output logic                 frame_end
);
    import metering_pkg::*;

    coord_t column;
    coord_t row;
    coord_t x_start;
    coord_t y_start;
    logic   previous_line_valid;
    logic   previous_frame_valid;

    logic [COORD_WIDTH:0] x_end;
    logic [COORD_WIDTH:0] y_end;

    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            column               <= '0;
            row                  <= '0;
            x_start              <= X_START_RESET;
            y_start              <= Y_START_RESET;
            previous_line_valid  <= 1'b0;
            previous_frame_valid <= 1'b0;
        end else begin
            previous_frame_valid <= pixels.frame_valid;
            if (!pixels.frame_valid) begin
                column              <= '0;
                row                 <= '0;
                previous_line_valid <= 1'b0;
                // Follow the registers between frames and freeze them once the frame starts
                x_start             <= window_x_start;
                y_start             <= window_y_start;
            end else begin
                previous_line_valid <= pixels.line_valid;
                if (pixels.line_valid) begin
                    column <= column + 1'b1;
                end else begin
                    column <= '0;
                    if (previous_line_valid) begin
                        row <= row + 1'b1;
                    end
                end
            end
        end
    end

    // One extra bit so a start near the top of the range cannot wrap
    assign x_end = {1'b0, x_start} + (COORD_WIDTH+1)'(WINDOW_SIZE);
    assign y_end = {1'b0, y_start} + (COORD_WIDTH+1)'(WINDOW_SIZE);

    assign in_window = pixels.frame_valid && pixels.line_valid &&
                       column >= x_start && {1'b0, column} < x_end &&
                       row >= y_start && {1'b0, row} < y_end;

    assign frame_end = previous_frame_valid && !pixels.frame_valid;

endmodule

// File: verif/metering_checker.sv
//////////////////////////////
// Metering protocol checker
// Watches AXI response holding, reset state
// and the timing of the result strobe
//////////////////////////////

`timescale 1ns/1ps

module metering_checker (
    input logic                    pixel_clock_in,
    input logic                    arst_n,
    input logic                    frame_valid,
    input logic                    result_strobe,
    input logic                    s_axi_awready,
    input logic                    s_axi_arready,
    input logic                    s_axi_bvalid,
    input logic                    s_axi_bready,
    input logic                    s_axi_rvalid,
    input logic                    s_axi_rready,
    input metering_pkg::axi_data_t s_axi_rdata
);

    bvalid_held: assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
        s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid)
        else $error("bvalid dropped before bready");

    // Read data must not change while the master stalls
    rvalid_held: assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
        s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata))
        else $error("rvalid or rdata changed before rready");

    reset_quiet: assert property (@(posedge pixel_clock_in)
        !arst_n |-> !s_axi_awready && !s_axi_arready && !s_axi_bvalid)
        else $error("AXI handshake signal high during reset");

    strobe_follows_fall: assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
        $fell(frame_valid) |=> result_strobe)
        else $error("No result strobe one cycle after frame end");

    strobe_only_after_fall: assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
        result_strobe |-> $past(frame_valid, 2) && !$past(frame_valid))
        else $error("Result strobe without a falling frame_valid");

endmodule

// File: verif/metering_tests.txt
// Columns: width height win_x win_y mode red green blue mid_x mid_y stall frame_count
// Mode 0 constant, 1 xorshift random, 2 patch inside window; FFFF means no window write
0500 02D0 FFFF FFFF 0000 0200 0100 03FF FFFF FFFF 0000 0001
0500 02D0 FFFF FFFF 0001 0000 0000 0000 FFFF FFFF 0003 0002
0500 02D0 02BC 00C8 0002 03FF 03FF 03FF FFFF FFFF 0005 0003
0500 02D0 FFFF FFFF 0002 00C0 0180 02C0 0000 0000 0001 0004
0500 02D0 FFFF FFFF 0002 0300 0200 0100 FFFF FFFF 0002 0005
0280 01E0 0040 0020 0001 0000 0000 0000 FFFF FFFF 0000 0006

// File: verif/tb_metering_top.sv
//////////////////////////////
// Metering testbench
// Replays the frames of the tests file, computes the
// window averages and checks them over AXI4-Lite
//////////////////////////////

`timescale 1ns/1ps

module tb_metering_top;
    import metering_pkg::*;

    localparam int FIELDS        = 12;
    localparam int MAX_TESTS     = 16;
    localparam int AXI_TIMEOUT   = 200;
    localparam int POLL_LIMIT    = 64;
    localparam int ROW_TIMEOUT   = 2000000;
    localparam int LINE_BLANK    = 4;
    localparam int FRAME_BLANK   = 8;
    localparam logic [15:0] SKIP = 16'hFFFF;

    logic        pixel_clock_in;
    logic        arst_n;
    pixel_t      pixel_red;
    pixel_t      pixel_green;
    pixel_t      pixel_blue;
    logic        line_valid;
    logic        frame_valid;
    axi_addr_t   s_axi_awaddr;
    logic        s_axi_awvalid;
    logic        s_axi_awready;
    axi_data_t   s_axi_wdata;
    logic        s_axi_wvalid;
    logic        s_axi_wready;
    logic [1:0]  s_axi_bresp;
    logic        s_axi_bvalid;
    logic        s_axi_bready;
    axi_addr_t   s_axi_araddr;
    logic        s_axi_arvalid;
    logic        s_axi_arready;
    axi_data_t   s_axi_rdata;
    logic [1:0]  s_axi_rresp;
    logic        s_axi_rvalid;
    logic        s_axi_rready;

    logic [15:0] test_data [0:FIELDS*MAX_TESTS-1];
    logic [31:0] rng_state;
    coord_t      current_x;
    coord_t      current_y;
    coord_t      pending_x;
    coord_t      pending_y;
    int          row_driven;
    int          mid_row;
    logic [63:0] red_sum;
    logic [63:0] green_sum;
    logic [63:0] blue_sum;
    int          window_pixels;

    metering_top dut (.*);

    initial begin
        pixel_clock_in = 1'b0;
        forever #2 pixel_clock_in = ~pixel_clock_in;
    end

    task automatic stop_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped after the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out waiting for %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: actual 0x%0h expected 0x%0h", name, actual, expected);
            stop_run();
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic inside_window(input int col, input int row);
        return col >= int'(current_x) && col < int'(current_x) + WINDOW_SIZE &&
               row >= int'(current_y) && row < int'(current_y) + WINDOW_SIZE;
    endfunction

    // 0 write ready, 1 bvalid, 2 arready, 3 rvalid, 4 frame reached mid_row
    function automatic logic condition_met(input int which);
        case (which)
            0:       return s_axi_awready && s_axi_wready;
            1:       return s_axi_bvalid;
            2:       return s_axi_arready;
            3:       return s_axi_rvalid;
            default: return row_driven >= mid_row;
        endcase
    endfunction

    // Samples on the falling edge, where DUT outputs are settled
    task automatic wait_for(input int which, input int limit, input string what);
        int cycles;
        cycles = 0;
        @(negedge pixel_clock_in);
        while (!condition_met(which)) begin
            if (cycles == limit) report_timeout(what);
            cycles++;
            @(negedge pixel_clock_in);
        end
    endtask

    task automatic axi_write(input axi_addr_t addr, input logic [31:0] data);
        @(posedge pixel_clock_in);
        s_axi_awaddr  <= addr;
        s_axi_awvalid <= 1'b1;
        s_axi_wdata   <= data;
        s_axi_wvalid  <= 1'b1;
        wait_for(0, AXI_TIMEOUT, "awready and wready");
        @(posedge pixel_clock_in);
        s_axi_awvalid <= 1'b0;
        s_axi_wvalid  <= 1'b0;
        s_axi_bready  <= 1'b1;
        wait_for(1, AXI_TIMEOUT, "bvalid");
        check_value("s_axi_bresp", 32'(s_axi_bresp), 32'h0);
        @(posedge pixel_clock_in);
        s_axi_bready <= 1'b0;
    endtask

    task automatic axi_read(input axi_addr_t addr, input int stall, output logic [31:0] data);
        @(posedge pixel_clock_in);
        s_axi_araddr  <= addr;
        s_axi_arvalid <= 1'b1;
        wait_for(2, AXI_TIMEOUT, "arready");
        @(posedge pixel_clock_in);
        s_axi_arvalid <= 1'b0;
        wait_for(3, AXI_TIMEOUT, "rvalid");
        repeat (stall) @(posedge pixel_clock_in);
        @(posedge pixel_clock_in);
        s_axi_rready <= 1'b1;
        @(negedge pixel_clock_in);
        data = s_axi_rdata;
        check_value("s_axi_rresp", 32'(s_axi_rresp), 32'h0);
        @(posedge pixel_clock_in);
        s_axi_rready <= 1'b0;
    endtask

    // Mode 0 constant colour, 1 xorshift noise, 2 colour patch inside the window only
    task automatic drive_frame(input int width, input int height, input int mode,
                               input pixel_t red_value, input pixel_t green_value,
                               input pixel_t blue_value);
        int     row;
        int     col;
        logic   flagged;
        pixel_t r;
        pixel_t g;
        pixel_t b;
        red_sum       = '0;
        green_sum     = '0;
        blue_sum      = '0;
        window_pixels = 0;
        row_driven    = 0;
        @(posedge pixel_clock_in);
        frame_valid <= 1'b1;
        repeat (LINE_BLANK) @(posedge pixel_clock_in);
        for (row = 0; row < height; row++) begin
            row_driven = row;
            for (col = 0; col < width; col++) begin
                flagged = inside_window(col, row);
                if (mode == 1) begin
                    rng_state = xorshift32(rng_state);
                    r = rng_state[9:0];
                    g = rng_state[19:10];
                    b = rng_state[29:20];
                end else if (mode == 2 && !flagged) begin
                    r = '0;
                    g = '0;
                    b = '0;
                end else begin
                    r = red_value;
                    g = green_value;
                    b = blue_value;
                end
                pixel_red   <= r;
                pixel_green <= g;
                pixel_blue  <= b;
                line_valid  <= 1'b1;
                if (flagged) begin
                    red_sum   = red_sum + 64'(r);
                    green_sum = green_sum + 64'(g);
                    blue_sum  = blue_sum + 64'(b);
                    window_pixels++;
                end
                @(posedge pixel_clock_in);
            end
            line_valid <= 1'b0;
            repeat (LINE_BLANK) @(posedge pixel_clock_in);
        end
        row_driven = height;
        frame_valid <= 1'b0;
        repeat (FRAME_BLANK) @(posedge pixel_clock_in);
    endtask

    task automatic run_test(input int index);
        int          base;
        int          stall;
        int          polls;
        logic [31:0] data;
        logic [31:0] expected;
        base  = index * FIELDS;
        stall = int'(test_data[base+10]);
        if (test_data[base+2] != SKIP) begin
            axi_write(REG_WINDOW_X, 32'(test_data[base+2]));
            axi_write(REG_WINDOW_Y, 32'(test_data[base+3]));
            current_x = test_data[base+2][11:0];
            current_y = test_data[base+3][11:0];
        end
        pending_x = current_x;
        pending_y = current_y;
        mid_row   = int'(test_data[base+1]) / 2;
        fork
            drive_frame(int'(test_data[base]), int'(test_data[base+1]),
                        int'(test_data[base+4]), test_data[base+5][9:0],
                        test_data[base+6][9:0], test_data[base+7][9:0]);
            if (test_data[base+8] != SKIP) begin
                // The tracker holds the old corner until the next frame starts
                wait_for(4, ROW_TIMEOUT, "the middle of the frame");
                axi_write(REG_WINDOW_X, 32'(test_data[base+8]));
                axi_write(REG_WINDOW_Y, 32'(test_data[base+9]));
                pending_x = test_data[base+8][11:0];
                pending_y = test_data[base+9][11:0];
            end
        join
        polls = 0;
        data  = '0;
        while (data[0] !== 1'b1) begin
            if (polls == POLL_LIMIT) report_timeout("the result-ready flag");
            axi_read(REG_STATUS, 0, data);
            polls++;
        end
        expected = {8'h00, red_sum[27:20], green_sum[27:20], blue_sum[27:20]};
        axi_read(REG_RESULT, stall, data);
        check_value("REG_RESULT", data, expected);
        if (test_data[base+4] == 16'h0 && window_pixels == WINDOW_SIZE * WINDOW_SIZE) begin
            expected = {8'h00, test_data[base+5][9:2], test_data[base+6][9:2],
                        test_data[base+7][9:2]};
            check_value("REG_RESULT constant", data, expected);
        end
        axi_read(REG_FRAME_COUNT, stall, data);
        check_value("REG_FRAME_COUNT", data, 32'(test_data[base+11]));
        axi_write(REG_STATUS, 32'h1);
        axi_read(REG_STATUS, stall, data);
        check_value("REG_STATUS", data, 32'h0);
        axi_read(REG_WINDOW_X, 0, data);
        check_value("REG_WINDOW_X", data, 32'(pending_x));
        axi_read(REG_WINDOW_Y, 0, data);
        check_value("REG_WINDOW_Y", data, 32'(pending_y));
        current_x = pending_x;
        current_y = pending_y;
    endtask

    initial begin
        logic [31:0] data;
        int          test;
        arst_n        = 1'b0;
        pixel_red     = '0;
        pixel_green   = '0;
        pixel_blue    = '0;
        line_valid    = 1'b0;
        frame_valid   = 1'b0;
        s_axi_awaddr  = '0;
        s_axi_awvalid = 1'b0;
        s_axi_wdata   = '0;
        s_axi_wvalid  = 1'b0;
        s_axi_bready  = 1'b0;
        s_axi_araddr  = '0;
        s_axi_arvalid = 1'b0;
        s_axi_rready  = 1'b0;
        rng_state     = 32'd67052;
        current_x     = 12'd384;
        current_y     = 12'd104;
        foreach (test_data[i]) test_data[i] = '0;
        $readmemh("verif/metering_tests.txt", test_data);
        repeat (4) @(posedge pixel_clock_in);
        arst_n <= 1'b1;
        repeat (2) @(posedge pixel_clock_in);
        axi_read(REG_WINDOW_X, 0, data);
        check_value("REG_WINDOW_X after reset", data, 32'd384);
        axi_read(REG_WINDOW_Y, 0, data);
        check_value("REG_WINDOW_Y after reset", data, 32'd104);
        axi_read(REG_RESULT, 0, data);
        check_value("REG_RESULT after reset", data, 32'h0);
        axi_read(REG_FRAME_COUNT, 0, data);
        check_value("REG_FRAME_COUNT after reset", data, 32'h0);
        axi_read(REG_STATUS, 0, data);
        check_value("REG_STATUS after reset", data, 32'h0);
        // A zero width marks the end of the table
        for (test = 0; test < MAX_TESTS && test_data[test*FIELDS] != 16'h0; test++) begin
            run_test(test);
        end
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

bind metering_top metering_checker u_checker (
    .pixel_clock_in (pixel_clock_in),
    .arst_n         (arst_n),
    .frame_valid    (frame_valid),
    .result_strobe  (result_strobe),
    .s_axi_awready  (s_axi_awready),
    .s_axi_arready  (s_axi_arready),
    .s_axi_bvalid   (s_axi_bvalid),
    .s_axi_bready   (s_axi_bready),
    .s_axi_rvalid   (s_axi_rvalid),
    .s_axi_rready   (s_axi_rready),
    .s_axi_rdata    (s_axi_rdata)
);
